/* hdl/exec_pkg.sv */
package exec_pkg;

    // register value, pc, immediate or result
    typedef logic [31:0] word_t;

    // sub, slt and sltu keep the branch compare codes
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b0001,
        AND  = 4'b0010,
        OR   = 4'b0011,
        XOR  = 4'b0100,
        SLT  = 4'b0101,
        SLL  = 4'b0110,
        SLTU = 4'b0111,
        SRL  = 4'b1000,
        SRA  = 4'b1001
    } alu_op_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RUN  = 2'b01,
        DONE = 2'b10
    } mul_state_t;

    // 0 to 32 multiply steps
    typedef logic [5:0] step_t;

    // count value during the 32nd step
    localparam step_t LAST_STEP = step_t'(31);

endpackage

/* hdl/hazard_pkg.sv */
package hazard_pkg;

    // source of a forwarded integer operand
    typedef enum logic [1:0] {
        MEM_ALU = 2'b00,
        WB      = 2'b01,
        MEM_PC4 = 2'b10,
        REG     = 2'b11
    } fwd_sel_t;

endpackage

/* hdl/alu.sv */
module alu
    import exec_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            XOR: begin
                result = a ^ b;
            end
            SLL: begin
                result = a << shamt;
            end
            SRL: begin
                result = a >> shamt;
            end
            SRA: begin
                result = word_t'($signed(a) >>> shamt);
            end
            SLT: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            SLTU: begin
                result = {31'b0, a < b};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

/* hdl/exec.sv */
module exec
    import exec_pkg::*;
    import hazard_pkg::*;
(
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    pc,
    input  word_t    pc_plus4,
    input  word_t    imm_ext,
    input  word_t    alu_result_m,
    input  word_t    pc_plus4_m,
    input  word_t    result_w,
    input  word_t    alu_out,
    input  word_t    product,
    input  fwd_sel_t fwd_a_sel,
    input  fwd_sel_t fwd_b_sel,
    input  alu_op_t  alu_op,
    input  logic     alu_src,
    input  logic     src_a_pc,
    input  logic     branch,
    input  logic     jump,
    input  logic     branch_invert,
    input  logic     mem_write,
    input  logic     mem_read,
    input  logic     zero,
    input  logic     mul_valid,
    input  logic     stall,
    output word_t    src_a,
    output word_t    src_b,
    output word_t    alu_result,
    output word_t    pc_target,
    output word_t    data_addr,
    output word_t    write_data,
    output logic     pc_src,
    output logic     mem_we,
    output logic     mem_re
);

    word_t rs1_fwd;
    word_t rs2_fwd;
    logic  branch_met;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_alu,
                                      word_t mem_pc4, word_t wb);
        case (sel)
            MEM_ALU: return mem_alu;
            WB:      return wb;
            MEM_PC4: return mem_pc4;
            default: return reg_val;
        endcase
    endfunction

    assign rs1_fwd = fwd_mux(fwd_a_sel, rs1_data, alu_result_m, pc_plus4_m, result_w);
    assign rs2_fwd = fwd_mux(fwd_b_sel, rs2_data, alu_result_m, pc_plus4_m, result_w);

    // auipc and jal take pc, jalr keeps rs1
    assign src_a = src_a_pc ? pc : rs1_fwd;
    assign src_b = alu_src ? imm_ext : rs2_fwd;

    // beq/bne on zero, blt/bge and bltu/bgeu on the set bit
    always_comb begin
        case (alu_op)
            SUB:       branch_met = zero ^ branch_invert;
            SLT, SLTU: branch_met = alu_out[0] ^ branch_invert;
            default:   branch_met = 1'b0;
        endcase
    end

    assign pc_src    = (branch_met & branch) | jump;
    assign pc_target = jump ? alu_out : pc + imm_ext;

    assign data_addr  = src_a + imm_ext;
    assign write_data = rs2_fwd;

    // no memory access while upstream is held
    assign mem_we = mem_write & ~stall;
    assign mem_re = mem_read & ~stall;

    assign alu_result = mul_valid ? product : alu_out;

endmodule

/* hdl/mul_ctrl.sv */
module mul_ctrl
    import exec_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic is_mul,
    input  logic multiplier_zero,
    input  logic last_step,
    output logic load,
    output logic step,
    output logic clear,
    output logic stall,
    output logic mul_valid
);

    mul_state_t state;
    mul_state_t state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        load       = 1'b0;
        clear      = 1'b0;
        step       = 1'b0;
        stall      = 1'b0;
        mul_valid  = 1'b0;
        case (state)
            IDLE: begin
                if (is_mul) begin
                    load       = 1'b1;
                    clear      = 1'b1;
                    stall      = 1'b1;
                    state_next = RUN;
                end
            end
            RUN: begin
                step  = 1'b1;
                stall = 1'b1;
                // early out once no multiplier bits remain
                if (multiplier_zero || last_step) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                mul_valid  = 1'b1;
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

/* hdl/mul_step_counter.sv */
module mul_step_counter
    import exec_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic step,
    output logic last_step
);

    step_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + step_t'(1);
        end
    end

    assign last_step = (count == LAST_STEP);

endmodule

/* hdl/mul_datapath.sv */
module mul_datapath
    import exec_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load,
    input  logic  step,
    input  word_t src_a,
    input  word_t src_b,
    output word_t product,
    output logic  multiplier_zero
);

    word_t multiplicand;
    word_t multiplier;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            multiplicand <= '0;
            multiplier   <= '0;
            product      <= '0;
        end else if (load) begin
            multiplicand <= src_a;
            multiplier   <= src_b;
            product      <= '0;
        end else if (step) begin
            // bits shifted past 31 drop out, only the low word is kept
            if (multiplier[0]) begin
                product <= product + multiplicand;
            end
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    assign multiplier_zero = (multiplier == '0);

endmodule

/* hdl/exec_unit.sv */
module exec_unit
    import exec_pkg::*;
    import hazard_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    pc,
    input  word_t    pc_plus4,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    imm_ext,
    input  alu_op_t  alu_op,
    input  logic     alu_src,
    input  logic     src_a_pc,
    input  logic     branch,
    input  logic     jump,
    input  logic     branch_invert,
    input  logic     mem_write,
    input  logic     mem_read,
    input  logic     is_mul,
    input  fwd_sel_t fwd_a_sel,
    input  fwd_sel_t fwd_b_sel,
    input  word_t    alu_result_m,
    input  word_t    pc_plus4_m,
    input  word_t    result_w,
    output word_t    alu_result,
    output word_t    pc_target,
    output logic     pc_src,
    output word_t    data_addr,
    output word_t    write_data,
    output logic     mem_we,
    output logic     mem_re,
    output logic     stall
);

    word_t src_a;
    word_t src_b;
    word_t alu_out;
    word_t product;
    logic  zero;
    logic  mul_valid;
    logic  load;
    logic  step;
    logic  clear;
    logic  multiplier_zero;
    logic  last_step;

    exec i_exec (
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .pc(pc),
        .pc_plus4(pc_plus4),
        .imm_ext(imm_ext),
        .alu_result_m(alu_result_m),
        .pc_plus4_m(pc_plus4_m),
        .result_w(result_w),
        .alu_out(alu_out),
        .product(product),
        .fwd_a_sel(fwd_a_sel),
        .fwd_b_sel(fwd_b_sel),
        .alu_op(alu_op),
        .alu_src(alu_src),
        .src_a_pc(src_a_pc),
        .branch(branch),
        .jump(jump),
        .branch_invert(branch_invert),
        .mem_write(mem_write),
        .mem_read(mem_read),
        .zero(zero),
        .mul_valid(mul_valid),
        .stall(stall),
        .src_a(src_a),
        .src_b(src_b),
        .alu_result(alu_result),
        .pc_target(pc_target),
        .data_addr(data_addr),
        .write_data(write_data),
        .pc_src(pc_src),
        .mem_we(mem_we),
        .mem_re(mem_re)
    );

    alu i_alu (
        .a(src_a),
        .b(src_b),
        .op(alu_op),
        .result(alu_out),
        .zero(zero)
    );

    // multiply sequencing
    mul_ctrl i_mul_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .is_mul(is_mul),
        .multiplier_zero(multiplier_zero),
        .last_step(last_step),
        .load(load),
        .step(step),
        .clear(clear),
        .stall(stall),
        .mul_valid(mul_valid)
    );

    mul_step_counter i_mul_step_counter (
        .clk(clk),
        .rst_n(rst_n),
        .clear(clear),
        .step(step),
        .last_step(last_step)
    );

    mul_datapath i_mul_datapath (
        .clk(clk),
        .rst_n(rst_n),
        .load(load),
        .step(step),
        .src_a(src_a),
        .src_b(src_b),
        .product(product),
        .multiplier_zero(multiplier_zero)
    );

endmodule

/* verif/exec_unit_checker.sv */
module exec_unit_checker
    import exec_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       stall,
    input logic       mem_we,
    input logic       mul_valid,
    input mul_state_t state
);

    // first sampled edge out of reset
    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !stall && !mul_valid)
        else $error("stall or mul_valid high right after reset release");

    no_write_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_we && stall))
        else $error("mem_we high while the stage is stalled");

    valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mul_valid |=> !mul_valid)
        else $error("mul_valid held for more than one cycle");

    state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {IDLE, RUN, DONE})
        else $error("multiply FSM state outside its encoding");

endmodule

/* verif/exec_unit_tb.sv */
module exec_unit_tb
    import exec_pkg::*;
    import hazard_pkg::*;
();

    localparam int NUM_VECTORS  = 25;
    localparam int VECTOR_WORDS = 11;
    localparam int NUM_RANDOM   = 20;
    localparam int CYCLE_LIMIT  = (NUM_VECTORS + NUM_RANDOM) * 40;

    logic     clk = 1'b0;
    logic     rst_n;
    word_t    pc;
    word_t    pc_plus4;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm_ext;
    alu_op_t  alu_op;
    logic     alu_src;
    logic     src_a_pc;
    logic     branch;
    logic     jump;
    logic     branch_invert;
    logic     mem_write;
    logic     mem_read;
    logic     is_mul;
    fwd_sel_t fwd_a_sel;
    fwd_sel_t fwd_b_sel;
    word_t    alu_result_m;
    word_t    pc_plus4_m;
    word_t    result_w;
    word_t    alu_result;
    word_t    pc_target;
    logic     pc_src;
    word_t    data_addr;
    word_t    write_data;
    logic     mem_we;
    logic     mem_re;
    logic     stall;

    word_t       vectors [0:NUM_VECTORS*VECTOR_WORDS-1];
    logic [31:0] rand_state;
    int          cycle_count;

    exec_unit dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .pc(pc),
        .pc_plus4(pc_plus4),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .imm_ext(imm_ext),
        .alu_op(alu_op),
        .alu_src(alu_src),
        .src_a_pc(src_a_pc),
        .branch(branch),
        .jump(jump),
        .branch_invert(branch_invert),
        .mem_write(mem_write),
        .mem_read(mem_read),
        .is_mul(is_mul),
        .fwd_a_sel(fwd_a_sel),
        .fwd_b_sel(fwd_b_sel),
        .alu_result_m(alu_result_m),
        .pc_plus4_m(pc_plus4_m),
        .result_w(result_w),
        .alu_result(alu_result),
        .pc_target(pc_target),
        .pc_src(pc_src),
        .data_addr(data_addr),
        .write_data(write_data),
        .mem_we(mem_we),
        .mem_re(mem_re),
        .stall(stall)
    );

    bind exec_unit exec_unit_checker checker0 (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .mem_we(mem_we),
        .mul_valid(mul_valid),
        .state(i_mul_ctrl.state)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // store data comes from the same source as forwarded rs2
    function automatic word_t forwarded_value(input fwd_sel_t sel, input word_t reg_val);
        word_t val;
        case (sel)
            MEM_ALU: val = alu_result_m;
            MEM_PC4: val = pc_plus4_m;
            WB:      val = result_w;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    task automatic check_word(input string name, input string field, input word_t expected,
                              input word_t actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "wrong value on %s", field);
        end
    endtask

    task automatic check_bit(input string name, input string field, input logic expected,
                             input logic actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %b, actual %b", name, field, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "wrong value on %s", field);
        end
    endtask

    task automatic set_idle_inputs();
        pc            = '0;
        pc_plus4      = 32'd4;
        rs1_data      = '0;
        rs2_data      = '0;
        imm_ext       = '0;
        alu_op        = ADD;
        alu_src       = 1'b0;
        src_a_pc      = 1'b0;
        branch        = 1'b0;
        jump          = 1'b0;
        branch_invert = 1'b0;
        mem_write     = 1'b0;
        mem_read      = 1'b0;
        is_mul        = 1'b0;
        fwd_a_sel     = REG;
        fwd_b_sel     = REG;
        alu_result_m  = '0;
        pc_plus4_m    = '0;
        result_w      = '0;
    endtask

    // inputs stay held until stall drops, the watchdog bounds the wait
    task automatic finish_multiply(input string name, input word_t expected);
        check_bit(name, "stall", 1'b1, stall);
        while (stall) begin
            check_bit(name, "mem_we", 1'b0, mem_we);
            check_bit(name, "mem_re", 1'b0, mem_re);
            @(posedge clk);
            #2;
        end
        check_word(name, "alu_result", expected, alu_result);
    endtask

    task automatic run_vector(input int idx);
        int    base;
        word_t ctrl;
        string name;
        base = idx * VECTOR_WORDS;
        ctrl = vectors[base];
        name = $sformatf("vec%0d", idx);
        @(posedge clk);
        #1;
        alu_op        = alu_op_t'(ctrl[3:0]);
        alu_src       = ctrl[4];
        src_a_pc      = ctrl[5];
        branch        = ctrl[6];
        jump          = ctrl[7];
        branch_invert = ctrl[8];
        mem_write     = ctrl[9];
        mem_read      = ctrl[10];
        is_mul        = ctrl[11];
        fwd_a_sel     = fwd_sel_t'(ctrl[13:12]);
        fwd_b_sel     = fwd_sel_t'(ctrl[15:14]);
        pc            = vectors[base + 1];
        pc_plus4      = vectors[base + 1] + 32'd4;
        rs1_data      = vectors[base + 2];
        rs2_data      = vectors[base + 3];
        imm_ext       = vectors[base + 4];
        alu_result_m  = vectors[base + 5];
        pc_plus4_m    = vectors[base + 6];
        result_w      = vectors[base + 7];
        #1;
        if (ctrl[11]) begin
            finish_multiply(name, vectors[base + 8]);
        end else begin
            check_bit(name, "stall", 1'b0, stall);
            check_word(name, "alu_result", vectors[base + 8], alu_result);
            check_word(name, "pc_target", vectors[base + 9], pc_target);
            check_word(name, "data_addr", vectors[base + 10], data_addr);
            check_word(name, "write_data", forwarded_value(fwd_b_sel, rs2_data), write_data);
            check_bit(name, "pc_src", ctrl[16], pc_src);
            check_bit(name, "mem_we", ctrl[9], mem_we);
            check_bit(name, "mem_re", ctrl[10], mem_re);
        end
    endtask

    task automatic run_multiply(input string name, input word_t a, input word_t b);
        @(posedge clk);
        #1;
        set_idle_inputs();
        rs1_data  = a;
        rs2_data  = b;
        is_mul    = 1'b1;
        // memory enables must stay masked while stalled
        mem_write = 1'b1;
        mem_read  = 1'b1;
        #1;
        // low word of the full product
        finish_multiply(name, a * b);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        word_t a;
        word_t b;
        $readmemh("verif/exec_unit_vectors.hex", vectors);
        set_idle_inputs();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        #1;
        check_bit("reset", "stall", 1'b0, stall);
        check_bit("reset", "mem_we", 1'b0, mem_we);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(i);
        end
        rand_state = 32'd89275;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_state = xorshift32(rand_state);
            a = rand_state;
            rand_state = xorshift32(rand_state);
            // shorter multipliers give early exits
            b = rand_state >> rand_state[4:0];
            run_multiply($sformatf("rand_mul%0d", i), a, b);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* exec_unit.f */
hdl/exec_pkg.sv
hdl/hazard_pkg.sv
hdl/alu.sv
hdl/exec.sv
hdl/mul_ctrl.sv
hdl/mul_step_counter.sv
hdl/mul_datapath.sv
hdl/exec_unit.sv
verif/exec_unit_checker.sv
verif/exec_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= exec_unit.f
BUILD_DIR ?= obj_dir
FLAGS     ?= -j 0

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR FLAGS"

test:
	$(VERILATOR) --binary --assert $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verif/exec_unit_vectors.hex */
// ctrl pc rs1 rs2 imm alu_result_m pc_plus4_m result_w exp_alu_result exp_pc_target exp_data_addr
// ctrl: [3:0] alu_op [4] alu_src [5] src_a_pc [6] branch [7] jump [8] branch_invert
// ctrl: [9] mem_write [10] mem_read [11] is_mul [13:12] fwd_a [15:14] fwd_b [16] exp pc_src
0000F000 00000100 00000005 00000007 00000010 00001000 00002004 00003000 0000000C 00000110 00000015
0000F002 00000100 F0F0F0F0 0FF00FF0 00000004 00001000 00002004 00003000 00F000F0 00000104 F0F0F0F4
0000F003 00000100 F0F0F0F0 0FF00FF0 00000004 00001000 00002004 00003000 FFF0FFF0 00000104 F0F0F0F4
0000F004 00000100 F0F0F0F0 0FF00FF0 00000004 00001000 00002004 00003000 FF00FF00 00000104 F0F0F0F4
0000F016 00000100 00000003 12345678 00000024 00001000 00002004 00003000 00000030 00000124 00000027
0000F008 00000100 80000000 0000001F 00000000 00001000 00002004 00003000 00000001 00000100 80000000
0000F009 00000100 80000000 00000004 00000000 00001000 00002004 00003000 F8000000 00000100 80000000
0000F030 00000100 AAAAAAAA 55555555 00001000 00001000 00002004 00003000 00001100 00001100 00001100
00004000 00000100 00000011 00000022 00000000 00001000 00002004 00003000 00004000 00000100 00001000
00009000 00000100 00000011 00000022 00000000 00001000 00002004 00003000 00005004 00000100 00003000
00002000 00000100 00000011 00000022 00000000 00001000 00002004 00003000 00003004 00000100 00002004
0001F041 00000200 00000007 00000007 00000040 00001000 00002004 00003000 00000000 00000240 00000047
0000F141 00000200 00000007 00000007 00000040 00001000 00002004 00003000 00000000 00000240 00000047
0001F045 00000200 FFFFFFFE 00000003 00000040 00001000 00002004 00003000 00000001 00000240 0000003E
0000F145 00000200 FFFFFFFE 00000003 00000040 00001000 00002004 00003000 00000001 00000240 0000003E
0000F047 00000200 FFFFFFFE 00000003 00000040 00001000 00002004 00003000 00000000 00000240 0000003E
0001F147 00000200 FFFFFFFE 00000003 00000040 00001000 00002004 00003000 00000000 00000240 0000003E
0001F0B0 00000200 00000000 00000000 00000040 00001000 00002004 00003000 00000240 00000240 00000240
0001F090 00000200 00001000 00000000 00000008 00001000 00002004 00003000 00001008 00001008 00001008
00007210 00000100 00004000 11111111 00000020 00001000 00002004 00003000 00004020 00000120 00004020
0000F410 00000100 00004000 DEADBEEF FFFFFFFC 00001000 00002004 00003000 00003FFC 000000FC 00003FFC
0000F800 00000100 00000007 00000006 00000000 00001000 00002004 00003000 0000002A 00000100 00000007
0000F800 00000100 12345678 00000000 00000000 00001000 00002004 00003000 00000000 00000100 12345678
0000F800 00000100 FFFFFFFF FFFFFFFF 00000000 00001000 00002004 00003000 00000001 00000100 FFFFFFFF
0000F800 00000100 00000003 80000000 00000000 00001000 00002004 00003000 80000000 00000100 00000003
